// ==== source/ppu_config.svh ====
`ifndef PPU_CONFIG_SVH
`define PPU_CONFIG_SVH

// instruction word and field widths
`define PPU_INSTR_W     32
`define PPU_OPCODE_W    6
`define PPU_FUNCT_W     6
`define PPU_REG_W       5

// control field widths
`define PPU_ALU_OP_W    4
`define PPU_SRC_SEL_W   3
`define PPU_DEST_W      2
`define PPU_SIZE_W      2
`define PPU_COND_W      3

`endif

// ==== source/isa_pkg.sv ====
`include "ppu_config.svh"

package isa_pkg;

        // primary opcode field, bits 31:26
        typedef enum logic [`PPU_OPCODE_W-1:0] {
                opc_special = 6'b000000,        // r-type, resolved by funct
                opc_regimm  = 6'b000001,        // resolved by rt
                opc_j       = 6'b000010,
                opc_jal     = 6'b000011,
                opc_beq     = 6'b000100,
                opc_bne     = 6'b000101,
                opc_blez    = 6'b000110,
                opc_bgtz    = 6'b000111,
                opc_addi    = 6'b001000,
                opc_addiu   = 6'b001001,
                opc_slti    = 6'b001010,
                opc_sltiu   = 6'b001011,
                opc_andi    = 6'b001100,
                opc_ori     = 6'b001101,
                opc_xori    = 6'b001110,
                opc_lui     = 6'b001111,
                opc_lb      = 6'b100000,
                opc_lh      = 6'b100001,
                opc_lw      = 6'b100011,
                opc_lbu     = 6'b100100,
                opc_lhu     = 6'b100101,
                opc_sb      = 6'b101000,
                opc_sh      = 6'b101001,
                opc_sw      = 6'b101011
        } opcode_e;

        typedef enum logic [`PPU_FUNCT_W-1:0] {
                fn_jr   = 6'b001000,
                fn_jalr = 6'b001001,
                fn_add  = 6'b100000,
                fn_addu = 6'b100001,
                fn_sub  = 6'b100010,
                fn_subu = 6'b100011,
                fn_and  = 6'b100100,
                fn_or   = 6'b100101,
                fn_xor  = 6'b100110,
                fn_nor  = 6'b100111,
                fn_slt  = 6'b101010,
                fn_sltu = 6'b101011
        } funct_e;

        // rt selects the regimm branch
        localparam logic [`PPU_REG_W-1:0] rt_bltz = 5'b00000;
        localparam logic [`PPU_REG_W-1:0] rt_bgez = 5'b00001;

        typedef enum logic [5:0] {
                op_nop = 6'd0,
                op_add, op_addu, op_sub, op_subu,
                op_and, op_or, op_xor, op_nor, op_slt, op_sltu,
                op_addi, op_addiu, op_andi, op_ori, op_xori,
                op_slti, op_sltiu, op_lui,
                op_lb, op_lbu, op_lh, op_lhu, op_lw,
                op_sb, op_sh, op_sw,
                op_beq, op_bne, op_bgtz, op_blez, op_bgez, op_bltz,
                op_j, op_jal, op_jr, op_jalr,
                op_illegal                      // unknown encoding
        } instr_op_e;

endpackage

// ==== source/ctrl_pkg.sv ====
`include "ppu_config.svh"

package ctrl_pkg;

        typedef enum logic [`PPU_ALU_OP_W-1:0] {
                alu_add = 4'd0,
                alu_sub,
                alu_and,
                alu_or,
                alu_xor,
                alu_nor,
                alu_slt,
                alu_sltu,
                alu_lui,
                alu_link                        // passes return address
        } alu_op_e;

        typedef enum logic [`PPU_SRC_SEL_W-1:0] {
                src_reg = 3'd0,
                src_imm_sext,
                src_imm_zext,
                src_imm_upper,                  // imm in upper half
                src_pc_link
        } src_operand_e;

        typedef enum logic [`PPU_DEST_W-1:0] {
                dest_rd = 2'd0,
                dest_rt,
                dest_r31
        } dest_sel_e;

        typedef enum logic [`PPU_SIZE_W-1:0] {
                size_byte = 2'd0,
                size_half,
                size_word
        } mem_size_e;

        typedef enum logic [`PPU_COND_W-1:0] {
                cond_eq = 3'd0,
                cond_ne,
                cond_gtz,
                cond_lez,
                cond_gez,
                cond_ltz
        } branch_cond_e;

        typedef struct packed {
                alu_op_e      alu_op;
                src_operand_e src_operand;
                logic         rf_we;
                dest_sel_e    dest_sel;
        } exec_ctrl_t;                          // 10 bits

        typedef struct packed {
                logic      mem_en;
                logic      mem_write;
                mem_size_e mem_size;
                logic      mem_sext;
        } mem_ctrl_t;                           // 5 bits

        typedef struct packed {
                logic         is_branch;
                branch_cond_e cond;
                logic         is_jump;
                logic         jump_reg;         // target from rs
                logic         link;
        } flow_ctrl_t;                          // 7 bits

        typedef struct packed {
                exec_ctrl_t exec;
                mem_ctrl_t  mem;
                flow_ctrl_t flow;
        } ctrl_word_t;                          // 22 bits

endpackage

// ==== source/instr_class_decoder.sv ====
`timescale 1ns/1ps
`include "ppu_config.svh"

module instr_class_decoder
        import isa_pkg::*;
(
        input  logic [`PPU_INSTR_W-1:0] instruction,
        output instr_op_e               op
);

        localparam int opc_lsb = `PPU_INSTR_W - `PPU_OPCODE_W;
        localparam int rt_lsb  = opc_lsb - 2 * `PPU_REG_W;     // rs sits between

        opcode_e               opcode;
        funct_e                funct;
        logic [`PPU_REG_W-1:0] rt;

        assign opcode = opcode_e'(instruction[`PPU_INSTR_W-1:opc_lsb]);
        assign funct  = funct_e'(instruction[`PPU_FUNCT_W-1:0]);
        assign rt     = instruction[rt_lsb +: `PPU_REG_W];

        always_comb begin
                op = op_illegal;
                if (instruction == '0) begin
                        op = op_nop;            // all-zero word, not sll
                end else begin
                        case (opcode)
                        opc_special: begin
                                case (funct)
                                fn_add:  op = op_add;
                                fn_addu: op = op_addu;
                                fn_sub:  op = op_sub;
                                fn_subu: op = op_subu;
                                fn_and:  op = op_and;
                                fn_or:   op = op_or;
                                fn_xor:  op = op_xor;
                                fn_nor:  op = op_nor;
                                fn_slt:  op = op_slt;
                                fn_sltu: op = op_sltu;
                                fn_jr:   op = op_jr;
                                fn_jalr: op = op_jalr;
                                default: op = op_illegal;       // shifts etc
                                endcase
                        end
                        opc_regimm: begin
                                if (rt == rt_bltz) begin
                                        op = op_bltz;
                                end else if (rt == rt_bgez) begin
                                        op = op_bgez;
                                end else begin
                                        op = op_illegal;        // linking forms
                                end
                        end
                        opc_j:     op = op_j;
                        opc_jal:   op = op_jal;
                        opc_beq:   op = op_beq;
                        opc_bne:   op = op_bne;
                        opc_blez:  op = op_blez;
                        opc_bgtz:  op = op_bgtz;
                        opc_addi:  op = op_addi;
                        opc_addiu: op = op_addiu;
                        opc_slti:  op = op_slti;
                        opc_sltiu: op = op_sltiu;
                        opc_andi:  op = op_andi;
                        opc_ori:   op = op_ori;
                        opc_xori:  op = op_xori;
                        opc_lui:   op = op_lui;
                        opc_lb:    op = op_lb;
                        opc_lh:    op = op_lh;
                        opc_lw:    op = op_lw;
                        opc_lbu:   op = op_lbu;
                        opc_lhu:   op = op_lhu;
                        opc_sb:    op = op_sb;
                        opc_sh:    op = op_sh;
                        opc_sw:    op = op_sw;
                        default:   op = op_illegal;
                        endcase
                end
        end

endmodule

// ==== source/exec_ctrl_decoder.sv ====
`timescale 1ns/1ps

module exec_ctrl_decoder
        import isa_pkg::*, ctrl_pkg::*;
(
        input  instr_op_e  op,
        output exec_ctrl_t exec
);

        always_comb begin
                exec = '0;

                // alu operation and second operand
                case (op)
                op_add, op_addu: exec.alu_op = alu_add;
                op_addi, op_addiu,
                op_lb, op_lbu, op_lh, op_lhu, op_lw,
                op_sb, op_sh, op_sw: begin
                        exec.alu_op      = alu_add;     // address calc for mem ops
                        exec.src_operand = src_imm_sext;
                end
                op_sub, op_subu,
                op_beq, op_bne, op_bgtz, op_blez, op_bgez, op_bltz: begin
                        exec.alu_op = alu_sub;  // branches compare by subtract
                end
                op_and:  exec.alu_op = alu_and;
                op_andi: begin
                        exec.alu_op      = alu_and;
                        exec.src_operand = src_imm_zext;
                end
                op_or:   exec.alu_op = alu_or;
                op_ori:  begin
                        exec.alu_op      = alu_or;
                        exec.src_operand = src_imm_zext;
                end
                op_xor:  exec.alu_op = alu_xor;
                op_xori: begin
                        exec.alu_op      = alu_xor;
                        exec.src_operand = src_imm_zext;
                end
                op_nor:  exec.alu_op = alu_nor;
                op_slt:  exec.alu_op = alu_slt;
                op_slti: begin
                        exec.alu_op      = alu_slt;
                        exec.src_operand = src_imm_sext;
                end
                op_sltu:  exec.alu_op = alu_sltu;
                op_sltiu: begin
                        exec.alu_op      = alu_sltu;
                        exec.src_operand = src_imm_sext;        // sext then unsigned compare
                end
                op_lui: begin
                        exec.alu_op      = alu_lui;
                        exec.src_operand = src_imm_upper;
                end
                op_jal, op_jalr: begin
                        exec.alu_op      = alu_link;
                        exec.src_operand = src_pc_link;
                end
                default: ;
                endcase

                // register write-back
                case (op)
                op_add, op_addu, op_sub, op_subu, op_and, op_or,
                op_xor, op_nor, op_slt, op_sltu, op_jalr: begin
                        exec.rf_we    = 1'b1;
                        exec.dest_sel = dest_rd;
                end
                op_addi, op_addiu, op_andi, op_ori, op_xori, op_slti, op_sltiu,
                op_lui, op_lb, op_lbu, op_lh, op_lhu, op_lw: begin
                        exec.rf_we    = 1'b1;
                        exec.dest_sel = dest_rt;
                end
                op_jal: begin
                        exec.rf_we    = 1'b1;
                        exec.dest_sel = dest_r31;       // implicit return register
                end
                default: ;
                endcase
        end

endmodule

// ==== source/mem_ctrl_decoder.sv ====
`timescale 1ns/1ps

module mem_ctrl_decoder
        import isa_pkg::*, ctrl_pkg::*;
(
        input  instr_op_e op,
        output mem_ctrl_t mem
);

        always_comb begin
                mem = '0;

                case (op)
                op_lb, op_lbu, op_lh, op_lhu, op_lw: mem.mem_en = 1'b1;
                op_sb, op_sh, op_sw: begin
                        mem.mem_en    = 1'b1;
                        mem.mem_write = 1'b1;
                end
                default: ;
                endcase

                case (op)
                op_lh, op_lhu, op_sh: mem.mem_size = size_half;
                op_lw, op_sw:         mem.mem_size = size_word;
                default:              mem.mem_size = size_byte;   // also the idle value
                endcase

                // only the signed sub-word loads extend
                mem.mem_sext = (op == op_lb) || (op == op_lh);
        end

        write_needs_en: assert final (!mem.mem_write || mem.mem_en)
                else $error("mem_write set without mem_en, op %s", op.name());

endmodule

// ==== source/flow_ctrl_decoder.sv ====
`timescale 1ns/1ps

module flow_ctrl_decoder
        import isa_pkg::*, ctrl_pkg::*;
(
        input  instr_op_e  op,
        output flow_ctrl_t flow
);

        always_comb begin
                flow = '0;

                case (op)
                op_beq, op_bne, op_bgtz, op_blez, op_bgez, op_bltz: flow.is_branch = 1'b1;
                op_j, op_jal, op_jr, op_jalr:                       flow.is_jump = 1'b1;
                default: ;
                endcase

                case (op)
                op_bne:  flow.cond = cond_ne;
                op_bgtz: flow.cond = cond_gtz;
                op_blez: flow.cond = cond_lez;
                op_bgez: flow.cond = cond_gez;
                op_bltz: flow.cond = cond_ltz;
                default: flow.cond = cond_eq;   // beq and non-branches
                endcase

                flow.jump_reg = (op == op_jr) || (op == op_jalr);
                flow.link     = (op == op_jal) || (op == op_jalr);
        end

        link_is_jump: assert final (!flow.link || flow.is_jump)
                else $error("link without jump, op %s", op.name());

        branch_xor_jump: assert final (!(flow.is_branch && flow.is_jump))
                else $error("branch and jump both set, op %s", op.name());

endmodule

// ==== source/id_ex_ctrl_stage.sv ====
`timescale 1ns/1ps

module id_ex_ctrl_stage
        import isa_pkg::*, ctrl_pkg::*;
(
        input  logic       clk,
        input  logic       arst_n,
        input  instr_op_e  op,
        input  exec_ctrl_t exec,
        input  mem_ctrl_t  mem,
        input  flow_ctrl_t flow,
        output ctrl_word_t ctrl,
        output logic       illegal_instr
);

        ctrl_word_t ctrl_next;

        assign ctrl_next = '{exec: exec, mem: mem, flow: flow};

        // id/ex boundary register
        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        ctrl          <= '0;
                        illegal_instr <= 1'b0;
                end else begin
                        ctrl          <= ctrl_next;
                        illegal_instr <= (op == op_illegal);
                end
        end

        // exec and mem decoders never claim the same op
        no_store_writeback: assert property (
                @(posedge clk) disable iff (!arst_n)
                !(ctrl.exec.rf_we && ctrl.mem.mem_write))
                else $error("rf_we and mem_write both set in ctrl word");

        // every group decoder must fall back to zero on illegal
        illegal_zero_word: assert property (
                @(posedge clk) disable iff (!arst_n)
                illegal_instr |-> (ctrl == '0))
                else $error("illegal_instr with nonzero ctrl %h", ctrl);

endmodule

// ==== source/ppu_ctrl_unit.sv ====
`timescale 1ns/1ps
`include "ppu_config.svh"

module ppu_ctrl_unit
        import isa_pkg::*, ctrl_pkg::*;
(
        input  logic                    clk,
        input  logic                    arst_n,
        input  logic [`PPU_INSTR_W-1:0] instruction,
        output ctrl_word_t              ctrl,
        output logic                    illegal_instr
);

        instr_op_e  op;         // decoded operation
        exec_ctrl_t exec;
        mem_ctrl_t  mem;
        flow_ctrl_t flow;

        instr_class_decoder i_class (.instruction(instruction), .op(op));

        exec_ctrl_decoder i_exec (.op(op), .exec(exec));

        mem_ctrl_decoder i_mem (.op(op), .mem(mem));

        flow_ctrl_decoder i_flow (.op(op), .flow(flow));

        id_ex_ctrl_stage i_stage (
                .clk           (clk),
                .arst_n        (arst_n),
                .op            (op),
                .exec          (exec),
                .mem           (mem),
                .flow          (flow),
                .ctrl          (ctrl),
                .illegal_instr (illegal_instr)
        );

endmodule

// ==== dv/ppu_ctrl_ref.svh ====
`ifndef PPU_CTRL_REF_SVH
`define PPU_CTRL_REF_SVH

// what the DUT should show one cycle after an instruction
typedef struct packed {
        logic       illegal;
        ctrl_word_t ctrl;
} ref_result_t;

function automatic ctrl_word_t alu_word(input alu_op_e alu, input src_operand_e src,
                                        input dest_sel_e dest);
        ctrl_word_t w;
        w      = '0;
        w.exec = '{alu, src, 1'b1, dest};       // every alu op writes back
        return w;
endfunction

function automatic ctrl_word_t mem_word(input logic write, input mem_size_e size,
                                        input logic sext);
        ctrl_word_t w;
        w      = '0;
        w.exec = '{alu_add, src_imm_sext, 1'b1, dest_rt};
        if (write) begin
                w.exec.rf_we    = 1'b0;         // stores write memory only
                w.exec.dest_sel = dest_rd;
        end
        w.mem  = '{1'b1, write, size, sext};
        return w;
endfunction

function automatic ctrl_word_t branch_word(input branch_cond_e cond);
        ctrl_word_t w;
        w      = '0;
        w.exec = '{alu_sub, src_reg, 1'b0, dest_rd};
        w.flow = '{1'b1, cond, 1'b0, 1'b0, 1'b0};
        return w;
endfunction

function automatic ref_result_t predict_ctrl(input logic [`PPU_INSTR_W-1:0] instr);
        ref_result_t r;
        logic [5:0]  opc;
        logic [5:0]  fn;
        logic [4:0]  rt;
        r   = '0;
        opc = instr[31:26];
        fn  = instr[5:0];
        rt  = instr[20:16];
        if (instr == '0) begin
                return r;                       // nop
        end
        case (opc)
        6'h00: begin
                case (fn)
                6'h20, 6'h21: r.ctrl = alu_word(alu_add, src_reg, dest_rd);
                6'h22, 6'h23: r.ctrl = alu_word(alu_sub, src_reg, dest_rd);
                6'h24:        r.ctrl = alu_word(alu_and, src_reg, dest_rd);
                6'h25:        r.ctrl = alu_word(alu_or, src_reg, dest_rd);
                6'h26:        r.ctrl = alu_word(alu_xor, src_reg, dest_rd);
                6'h27:        r.ctrl = alu_word(alu_nor, src_reg, dest_rd);
                6'h2a:        r.ctrl = alu_word(alu_slt, src_reg, dest_rd);
                6'h2b:        r.ctrl = alu_word(alu_sltu, src_reg, dest_rd);
                6'h08:        r.ctrl.flow = '{1'b0, cond_eq, 1'b1, 1'b1, 1'b0};    // jr
                6'h09: begin
                        r.ctrl      = alu_word(alu_link, src_pc_link, dest_rd);
                        r.ctrl.flow = '{1'b0, cond_eq, 1'b1, 1'b1, 1'b1};
                end
                default:      r.illegal = 1'b1;
                endcase
        end
        6'h01: begin
                if (rt == 5'd0) begin
                        r.ctrl = branch_word(cond_ltz);
                end else if (rt == 5'd1) begin
                        r.ctrl = branch_word(cond_gez);
                end else begin
                        r.illegal = 1'b1;       // link forms are not kept
                end
        end
        6'h02: r.ctrl.flow = '{1'b0, cond_eq, 1'b1, 1'b0, 1'b0};
        6'h03: begin
                r.ctrl      = alu_word(alu_link, src_pc_link, dest_r31);
                r.ctrl.flow = '{1'b0, cond_eq, 1'b1, 1'b0, 1'b1};
        end
        6'h04: r.ctrl = branch_word(cond_eq);
        6'h05: r.ctrl = branch_word(cond_ne);
        6'h06: r.ctrl = branch_word(cond_lez);
        6'h07: r.ctrl = branch_word(cond_gtz);
        6'h08, 6'h09: r.ctrl = alu_word(alu_add, src_imm_sext, dest_rt);
        6'h0a: r.ctrl = alu_word(alu_slt, src_imm_sext, dest_rt);
        6'h0b: r.ctrl = alu_word(alu_sltu, src_imm_sext, dest_rt);
        6'h0c: r.ctrl = alu_word(alu_and, src_imm_zext, dest_rt);
        6'h0d: r.ctrl = alu_word(alu_or, src_imm_zext, dest_rt);
        6'h0e: r.ctrl = alu_word(alu_xor, src_imm_zext, dest_rt);
        6'h0f: r.ctrl = alu_word(alu_lui, src_imm_upper, dest_rt);
        6'h20: r.ctrl = mem_word(1'b0, size_byte, 1'b1);       // lb
        6'h24: r.ctrl = mem_word(1'b0, size_byte, 1'b0);       // lbu
        6'h21: r.ctrl = mem_word(1'b0, size_half, 1'b1);       // lh
        6'h25: r.ctrl = mem_word(1'b0, size_half, 1'b0);       // lhu
        6'h23: r.ctrl = mem_word(1'b0, size_word, 1'b0);       // lw
        6'h28: r.ctrl = mem_word(1'b1, size_byte, 1'b0);       // sb
        6'h29: r.ctrl = mem_word(1'b1, size_half, 1'b0);       // sh
        6'h2b: r.ctrl = mem_word(1'b1, size_word, 1'b0);       // sw
        default: r.illegal = 1'b1;
        endcase
        return r;
endfunction

// instruction builders, random bits fill the register and immediate fields
function automatic logic [`PPU_INSTR_W-1:0] r_type_instr(input logic [5:0] fn,
                                                         input logic [31:0] rnd);
        return {6'h00, rnd[14:0], 5'd0, fn};   // rs rt rd, shamt zero
endfunction

function automatic logic [`PPU_INSTR_W-1:0] opcode_instr(input logic [5:0] opc,
                                                         input logic [31:0] rnd);
        return {opc, rnd[25:0]};
endfunction

function automatic logic [`PPU_INSTR_W-1:0] regimm_instr(input logic [4:0] rt,
                                                         input logic [31:0] rnd);
        return {6'h01, rnd[4:0], rt, rnd[20:5]};
endfunction

`endif

// ==== dv/tb_ppu_ctrl.sv ====
`timescale 1ns/1ps
`include "ppu_config.svh"

module tb_ppu_ctrl
        import ctrl_pkg::*;
();

`include "ppu_ctrl_ref.svh"

        logic                    clk;
        logic                    arst_n;
        logic [`PPU_INSTR_W-1:0] instruction;
        ctrl_word_t              ctrl;
        logic                    illegal_instr;

        ref_result_t             expected;
        logic [`PPU_INSTR_W-1:0] prev_instr;    // instruction behind expected
        integer                  seed = 40573;
        int                      mismatches = 0;
        int                      timeouts = 0;
        int                      tests_run = 0;
        int                      tests_failed = 0;
        int                      errors_at_start = 0;
        string                   test_name;

        localparam int idle_limit = 8;

        // alu functs first, then jr and jalr
        localparam logic [5:0] r_functs [12] = '{6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25,
                                                 6'h26, 6'h27, 6'h2a, 6'h2b, 6'h08, 6'h09};
        // immediates, loads and stores, branches and jumps
        localparam logic [5:0] i_opcodes [22] = '{6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d,
                                                  6'h0e, 6'h0f, 6'h20, 6'h24, 6'h21, 6'h25,
                                                  6'h23, 6'h28, 6'h29, 6'h2b, 6'h04, 6'h05,
                                                  6'h06, 6'h07, 6'h02, 6'h03};

        ppu_ctrl_unit i_dut (
                .clk           (clk),
                .arst_n        (arst_n),
                .instruction   (instruction),
                .ctrl          (ctrl),
                .illegal_instr (illegal_instr)
        );

        always #2 clk = ~clk;

        // one-cycle model of the id/ex register
        always @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        expected   <= '0;
                        prev_instr <= '0;
                end else begin
                        expected   <= predict_ctrl(instruction);
                        prev_instr <= instruction;
                end
        end

        ctrl_matches: assert property (@(posedge clk) disable iff (!arst_n)
                ctrl == expected.ctrl)
                else begin
                        mismatches++;
                        $display("MISMATCH ctrl instr %h expected %h actual %h",
                                 $sampled(prev_instr), $sampled(expected.ctrl), $sampled(ctrl));
                end

        illegal_matches: assert property (@(posedge clk) disable iff (!arst_n)
                illegal_instr == expected.illegal)
                else begin
                        mismatches++;
                        $display("MISMATCH illegal_instr instr %h expected %h actual %h",
                                 $sampled(prev_instr), $sampled(expected.illegal),
                                 $sampled(illegal_instr));
                end

        reset_clears: assert property (@(posedge clk)
                !arst_n |-> (ctrl == '0 && !illegal_instr))
                else begin
                        mismatches++;
                        $display("MISMATCH ctrl in reset expected 000000 actual %h, illegal_instr %h",
                                 $sampled(ctrl), $sampled(illegal_instr));
                end

        task automatic issue_instr(input logic [`PPU_INSTR_W-1:0] instr);
                @(posedge clk);
                #0.5;
                instruction = instr;
        endtask

        // feed a nop and wait for the zero word to come out
        task automatic drain_pipe();
                int n;
                n = 0;
                issue_instr('0);
                @(posedge clk);
                #0.5;
                while ((ctrl != '0 || illegal_instr) && n < idle_limit) begin
                        @(posedge clk);
                        #0.5;
                        n++;
                end
                if (ctrl != '0 || illegal_instr) begin
                        timeouts++;
                        $display("timeout: control word stayed nonzero after test %s", test_name);
                end
        endtask

        task automatic await_illegal(input logic [`PPU_INSTR_W-1:0] instr);
                int n;
                n = 0;
                issue_instr(instr);
                @(posedge clk);
                #0.5;
                while (!illegal_instr && n < idle_limit) begin
                        @(posedge clk);
                        #0.5;
                        n++;
                end
                if (!illegal_instr) begin
                        timeouts++;
                        $display("timeout: illegal_instr never rose for instruction %h", instr);
                end
        endtask

        task automatic start_test(input string name);
                test_name       = name;
                errors_at_start = mismatches + timeouts;
        endtask

        task automatic end_test();
                int errs;
                drain_pipe();
                errs = mismatches + timeouts - errors_at_start;
                tests_run++;
                if (errs != 0) begin
                        tests_failed++;
                end
                $display("test %-8s %s, %0d errors", test_name, (errs == 0) ? "ok" : "bad", errs);
        endtask

        initial begin
                int unsigned pick;
                logic [31:0] rnd;
                clk         = 1'b0;
                arst_n      = 1'b1;
                instruction = opcode_instr(6'h23, $random(seed));      // lw, nonzero word

                start_test("reset");
                #0.5;
                arst_n = 1'b0;
                issue_instr(32'hfc00_0000);                             // illegal while in reset
                issue_instr(opcode_instr(6'h23, $random(seed)));
                @(posedge clk);
                #0.5;
                arst_n = 1'b1;
                end_test();

                start_test("alu");
                for (int k = 0; k < 10; k++) begin
                        repeat (3) issue_instr(r_type_instr(r_functs[k], $random(seed)));
                end
                for (int k = 0; k < 8; k++) begin
                        repeat (3) issue_instr(opcode_instr(i_opcodes[k], $random(seed)));
                end
                end_test();

                start_test("mem");
                for (int k = 8; k < 16; k++) begin
                        repeat (3) issue_instr(opcode_instr(i_opcodes[k], $random(seed)));
                end
                end_test();

                start_test("flow");
                for (int k = 16; k < 22; k++) begin
                        repeat (3) issue_instr(opcode_instr(i_opcodes[k], $random(seed)));
                end
                issue_instr(regimm_instr(5'd0, $random(seed)));         // bltz
                issue_instr(regimm_instr(5'd1, $random(seed)));         // bgez
                issue_instr(r_type_instr(r_functs[10], $random(seed)));
                issue_instr(r_type_instr(r_functs[11], $random(seed)));
                end_test();

                start_test("decode");
                drain_pipe();                                           // plain nop
                await_illegal(32'hfc00_0000);
                await_illegal(opcode_instr(6'h10, $random(seed)));     // coprocessor
                await_illegal(opcode_instr(6'h22, $random(seed)));     // lwl
                await_illegal(r_type_instr(6'h00, 32'h0000_1234));     // shift
                await_illegal(r_type_instr(6'h18, $random(seed)));     // mult
                await_illegal(regimm_instr(5'h10, $random(seed)));     // bltzal
                await_illegal(regimm_instr(5'h11, $random(seed)));
                end_test();

                start_test("mix");
                for (int k = 0; k < 200; k++) begin
                        pick = $unsigned($random(seed));
                        rnd  = $random(seed);
                        case (pick % 5)
                        0:       issue_instr(r_type_instr(r_functs[(pick / 5) % 12], rnd));
                        1, 2:    issue_instr(opcode_instr(i_opcodes[(pick / 5) % 22], rnd));
                        3:       issue_instr(regimm_instr({4'd0, pick[8]}, rnd));
                        default: issue_instr(rnd);                      // raw word
                        endcase
                end
                end_test();

                $display("tests %0d, failed %0d, mismatches %0d, timeouts %0d",
                         tests_run, tests_failed, mismatches, timeouts);
                if (tests_failed == 0 && mismatches == 0 && timeouts == 0) begin
                        $display("*** PASSED ***");
                end else begin
                        $display("*** FAILED ***");
                end
                $finish;
        end

endmodule

// ==== tb.f ====
+incdir+source
+incdir+dv
source/isa_pkg.sv
source/ctrl_pkg.sv
source/instr_class_decoder.sv
source/exec_ctrl_decoder.sv
source/mem_ctrl_decoder.sv
source/flow_ctrl_decoder.sv
source/id_ex_ctrl_stage.sv
source/ppu_ctrl_unit.sv
dv/tb_ppu_ctrl.sv
